/* hdl/cm_pkg.sv */
// shared sizes and types for the cell address manager
package cm_pkg;

    localparam int NUM_CELLS = 16;   // buffer cells
    localparam int NUM_PORTS = 4;    // output ports
    localparam int NUM_PRIOS = 4;    // priorities per port

    localparam int ADDR_W  = $clog2(NUM_CELLS);
    localparam int PORT_W  = $clog2(NUM_PORTS);
    localparam int PRIO_W  = $clog2(NUM_PRIOS);
    localparam int COUNT_W = $clog2(NUM_CELLS + 1);   // 0 .. NUM_CELLS

    typedef logic [ADDR_W-1:0]    cell_addr_t;
    typedef logic [PORT_W-1:0]    port_t;
    typedef logic [PRIO_W-1:0]    prio_t;
    typedef logic [NUM_PRIOS-1:0] prio_mask_t;    // one nonempty bit per priority
    typedef logic [COUNT_W-1:0]   cell_count_t;

    // destination of a write or source of a read
    typedef struct packed {
        port_t port;
        prio_t prio;
    } dest_t;

    // allocation made in the current cycle
    typedef struct packed {
        logic       valid;
        cell_addr_t addr;
        dest_t      dest;
    } grant_t;

    // cell handed back to a reader
    typedef struct packed {
        cell_addr_t addr;
        logic       last;   // last cell of its packet
    } rd_cell_t;

endpackage

/* hdl/cell_pool.sv */
`timescale 1ns/1ns
// free cell FIFO, allocation grant, per-cell last flags and cell return
module cell_pool (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_req,
    input  logic               eop,
    input  cm_pkg::dest_t      wr_dest,
    output cm_pkg::grant_t     grant,
    output logic               alloc_valid,
    output cm_pkg::cell_addr_t alloc_addr,
    output logic               pool_empty,
    input  logic               free_req,
    input  cm_pkg::cell_addr_t free_addr,
    output logic               free_last
);
    import cm_pkg::*;

    cell_addr_t           free_fifo [NUM_CELLS];
    cell_addr_t           head;        // next cell handed out
    cell_addr_t           tail;        // slot for the next returned cell
    cell_count_t          count;
    cell_count_t          count_next;
    logic [NUM_CELLS-1:0] last_flag;
    logic [NUM_CELLS-1:0] in_use;
    logic                 grant_seen;  // any grant since reset

    // alloc only when eop is low and a cell is left
    assign grant.valid = wr_req && !eop && (count != '0);
    assign grant.addr  = free_fifo[head];
    assign grant.dest  = wr_dest;

    assign pool_empty = (count == '0);   // registered count, so one cycle late
    assign free_last  = last_flag[free_addr];

    always_comb begin
        count_next = count;
        if (grant.valid && !free_req) begin
            count_next = count - 1'b1;
        end else if (free_req && !grant.valid) begin
            count_next = count + 1'b1;
        end
    end

    // pointers wrap on their own, NUM_CELLS is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CELLS; i++) begin
                free_fifo[i] <= cell_addr_t'(i);   // pool starts as 0, 1, .. 15
            end
            head        <= '0;
            tail        <= '0;   // full FIFO, tail sits on head
            count       <= cell_count_t'(NUM_CELLS);
            last_flag   <= '0;
            in_use      <= '0;
            grant_seen  <= 1'b0;
            alloc_valid <= 1'b0;
        end else begin
            count       <= count_next;
            alloc_valid <= grant.valid;
            if (grant.valid) begin
                head               <= head + 1'b1;
                in_use[grant.addr] <= 1'b1;
                grant_seen         <= 1'b1;
            end
            if (free_req) begin
                free_fifo[tail]   <= free_addr;   // returned cell goes behind the others
                tail              <= tail + 1'b1;
                in_use[free_addr] <= 1'b0;
            end
            // alloc_addr still holds the most recent grant here
            if (eop && grant_seen) begin
                last_flag[alloc_addr] <= 1'b1;
            end
            // a cell going back to the pool leaves with its flag down
            if (free_req) begin
                last_flag[free_addr] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant.valid) begin
            alloc_addr <= grant.addr;
        end
    end

    a_count_range: assert property (
        @(posedge clk) disable iff (rst) count <= cell_count_t'(NUM_CELLS));

    // a reader may only hand back a cell that was granted and not yet freed
    a_free_in_use: assert property (
        @(posedge clk) disable iff (rst) free_req |-> in_use[free_addr]);

endmodule

/* hdl/port_queue.sv */
`timescale 1ns/1ns
// per-priority cell address FIFOs for one output port
module port_queue #(
    parameter int PORT_ID = 0
) (
    input  logic               clk,
    input  logic               rst,
    input  cm_pkg::grant_t     grant,
    input  logic               deq,
    input  cm_pkg::prio_t      deq_prio,
    output cm_pkg::cell_addr_t head_addr,
    output cm_pkg::prio_mask_t nonempty
);
    import cm_pkg::*;

    cell_addr_t  mem    [NUM_PRIOS][NUM_CELLS];   // as deep as the buffer, never overflows
    cell_addr_t  rd_ptr [NUM_PRIOS];
    cell_addr_t  wr_ptr [NUM_PRIOS];
    cell_count_t cnt    [NUM_PRIOS];
    logic        enq;
    prio_t       enq_prio;
    prio_mask_t  enq_mask;
    prio_mask_t  deq_mask;

    // only grants aimed at this port
    assign enq      = grant.valid && (grant.dest.port == port_t'(PORT_ID));
    assign enq_prio = grant.dest.prio;

    assign head_addr = mem[deq_prio][rd_ptr[deq_prio]];

    always_comb begin
        enq_mask           = '0;
        deq_mask           = '0;
        enq_mask[enq_prio] = enq;
        deq_mask[deq_prio] = deq;
    end

    always_comb begin
        for (int p = 0; p < NUM_PRIOS; p++) begin
            nonempty[p] = (cnt[p] != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < NUM_PRIOS; p++) begin
                rd_ptr[p] <= '0;
                wr_ptr[p] <= '0;
                cnt[p]    <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PRIOS; p++) begin
                if (enq_mask[p]) begin
                    wr_ptr[p] <= wr_ptr[p] + 1'b1;
                end
                if (deq_mask[p]) begin
                    rd_ptr[p] <= rd_ptr[p] + 1'b1;
                end
                // both on one priority leaves the count alone
                if (enq_mask[p] && !deq_mask[p]) begin
                    cnt[p] <= cnt[p] + 1'b1;
                end else if (deq_mask[p] && !enq_mask[p]) begin
                    cnt[p] <= cnt[p] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            mem[enq_prio][wr_ptr[enq_prio]] <= grant.addr;
        end
    end

    // the selector must only pop a priority it saw as nonempty
    a_deq_nonempty: assert property (
        @(posedge clk) disable iff (rst) deq |-> nonempty[deq_prio]);

    // pool hands out at most NUM_CELLS cells, so a priority can't fill past that
    a_enq_not_full: assert property (
        @(posedge clk) disable iff (rst) enq |-> (cnt[enq_prio] != cell_count_t'(NUM_CELLS)));

endmodule

/* hdl/dequeue_select.sv */
`timescale 1ns/1ns
// read request check, routing to one port queue, cell return and read result register
module dequeue_select (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       rd_req,
    input  cm_pkg::dest_t                              rd_dest,
    input  cm_pkg::cell_addr_t [cm_pkg::NUM_PORTS-1:0] heads,
    input  cm_pkg::prio_mask_t [cm_pkg::NUM_PORTS-1:0] nonempty,
    input  logic                                       free_last,
    output logic [cm_pkg::NUM_PORTS-1:0]               deq,
    output logic                                       free_req,
    output cm_pkg::cell_addr_t                         free_addr,
    output logic                                       rd_valid,
    output cm_pkg::rd_cell_t                           rd_cell
);
    import cm_pkg::*;

    prio_mask_t sel_mask;   // occupancy of the addressed port
    logic       hit;

    assign sel_mask = nonempty[rd_dest.port];
    assign hit      = rd_req && sel_mask[rd_dest.prio];   // empty queue gives nothing

    // head of the chosen queue goes straight back to the pool
    assign free_req  = hit;
    assign free_addr = heads[rd_dest.port];

    always_comb begin
        deq               = '0;
        deq[rd_dest.port] = hit;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            rd_cell.addr <= free_addr;
            rd_cell.last <= free_last;   // flag from the pool before it clears
        end
    end

    a_deq_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(deq));

endmodule

/* hdl/cell_manager.sv */
`timescale 1ns/1ns
// cell address manager top: free cell pool, per-port address queues, dequeue selector
module cell_manager (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       wr_req,
    input  logic                                       eop,
    input  cm_pkg::dest_t                              wr_dest,
    input  logic                                       rd_req,
    input  cm_pkg::dest_t                              rd_dest,
    output logic                                       alloc_valid,
    output cm_pkg::cell_addr_t                         alloc_addr,
    output logic                                       pool_empty,
    output logic                                       rd_valid,
    output cm_pkg::rd_cell_t                           rd_cell,
    output cm_pkg::prio_mask_t [cm_pkg::NUM_PORTS-1:0] queue_nonempty
);
    import cm_pkg::*;

    grant_t                     grant;       // this cycle's allocation, to all queues
    cell_addr_t [NUM_PORTS-1:0] heads;       // head of each port at rd_dest.prio
    logic [NUM_PORTS-1:0]       deq;
    logic                       free_req;
    cell_addr_t                 free_addr;
    logic                       free_last;

    cell_pool pool0 (
        .clk         (clk),
        .rst         (rst),
        .wr_req      (wr_req),
        .eop         (eop),
        .wr_dest     (wr_dest),
        .grant       (grant),
        .alloc_valid (alloc_valid),
        .alloc_addr  (alloc_addr),
        .pool_empty  (pool_empty),
        .free_req    (free_req),
        .free_addr   (free_addr),
        .free_last   (free_last)
    );

    // read priority is broadcast, only the deq bit picks the port
    for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_port
        port_queue #(
            .PORT_ID (i)
        ) queue0 (
            .clk       (clk),
            .rst       (rst),
            .grant     (grant),
            .deq       (deq[i]),
            .deq_prio  (rd_dest.prio),
            .head_addr (heads[i]),
            .nonempty  (queue_nonempty[i])
        );
    end

    dequeue_select sel0 (
        .clk       (clk),
        .rst       (rst),
        .rd_req    (rd_req),
        .rd_dest   (rd_dest),
        .heads     (heads),
        .nonempty  (queue_nonempty),
        .free_last (free_last),
        .deq       (deq),
        .free_req  (free_req),
        .free_addr (free_addr),
        .rd_valid  (rd_valid),
        .rd_cell   (rd_cell)
    );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ns
// free-running testbench clock
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;   // 50 ns high, 50 ns low
    end

endmodule

/* testbench/tb_cell_manager.sv */
`timescale 1ns/1ns
// cell manager testbench: directed and random stimulus, reference model, compare tasks, timeout
module tb_cell_manager;
    import cm_pkg::*;

    localparam int RESET_CYCLES    = 5;
    localparam int DIRECTED_CYCLES = 40;
    localparam int RANDOM_CYCLES   = 600;
    // reset, directed and random phases plus a wide margin
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 155;

    logic                         clk;
    logic                         rst;
    logic                         wr_req;
    logic                         eop;
    dest_t                        wr_dest;
    logic                         rd_req;
    dest_t                        rd_dest;
    logic                         alloc_valid;
    cell_addr_t                   alloc_addr;
    logic                         pool_empty;
    logic                         rd_valid;
    rd_cell_t                     rd_cell;
    prio_mask_t [NUM_PORTS-1:0]   queue_nonempty;

    // reference model
    cell_addr_t           free_q [$];
    cell_addr_t           q_model [NUM_PORTS*NUM_PRIOS][$];   // indexed by {port, prio}
    logic [NUM_CELLS-1:0] m_last;
    cell_addr_t           m_last_granted;
    logic                 m_granted_any;
    logic                 exp_alloc_valid;
    cell_addr_t           exp_alloc_addr;
    logic                 exp_rd_valid;
    rd_cell_t             exp_rd_cell;

    int         flag_errors = 0;
    int         addr_errors = 0;
    int         cell_errors = 0;
    int         mask_errors = 0;
    int         cycles = 0;
    integer     seed = 7087;
    logic [31:0] r;
    dest_t      idle;
    dest_t      wd;
    dest_t      rdd;
    logic       rd_on;

    tb_clock #(.PERIOD(100)) clk0 (.clk(clk));

    cell_manager dut0 (
        .clk            (clk),
        .rst            (rst),
        .wr_req         (wr_req),
        .eop            (eop),
        .wr_dest        (wr_dest),
        .rd_req         (rd_req),
        .rd_dest        (rd_dest),
        .alloc_valid    (alloc_valid),
        .alloc_addr     (alloc_addr),
        .pool_empty     (pool_empty),
        .rd_valid       (rd_valid),
        .rd_cell        (rd_cell),
        .queue_nonempty (queue_nonempty)
    );

    function automatic dest_t to_dest(input int port, input int prio);
        dest_t d;
        d.port = port_t'(port);
        d.prio = prio_t'(prio);
        return d;
    endfunction

    function automatic prio_mask_t model_mask(input int port);
        prio_mask_t m;
        for (int q = 0; q < NUM_PRIOS; q++) begin
            m[q] = (q_model[port*NUM_PRIOS+q].size() != 0);
        end
        return m;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("ERROR %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input cell_addr_t got, input cell_addr_t exp);
        if (got !== exp) begin
            addr_errors++;
            $display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_cell(input string name, input rd_cell_t got, input rd_cell_t exp);
        if (got !== exp) begin
            cell_errors++;
            $display("ERROR %0t %s: got addr %h last %b, expected addr %h last %b",
                     $time, name, got.addr, got.last, exp.addr, exp.last);
        end
    endtask

    task automatic check_mask(input string name, input prio_mask_t got, input prio_mask_t exp);
        if (got !== exp) begin
            mask_errors++;
            $display("ERROR %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs();
        check_bit("alloc_valid", alloc_valid, exp_alloc_valid);
        if (exp_alloc_valid) check_addr("alloc_addr", alloc_addr, exp_alloc_addr);
        check_bit("rd_valid", rd_valid, exp_rd_valid);
        if (exp_rd_valid) check_cell("rd_cell", rd_cell, exp_rd_cell);
        check_bit("pool_empty", pool_empty, free_q.size() == 0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_mask($sformatf("queue_nonempty[%0d]", p), queue_nonempty[p], model_mask(p));
        end
    endtask

    // drive one cycle, step the model, then check the registered results
    task automatic run_cycle(input logic wr, input logic e, input dest_t wdst,
                             input logic rd, input dest_t rdst);
        logic       grant_ok;
        logic       hit;
        cell_addr_t g_addr;
        cell_addr_t f_addr;
        logic       f_last;
        wr_req  = wr;
        eop     = e;
        wr_dest = wdst;
        rd_req  = rd;
        rd_dest = rdst;
        grant_ok = wr && !e && (free_q.size() != 0);   // count as it stood before the edge
        hit      = rd && (q_model[{rdst.port, rdst.prio}].size() != 0);
        if (grant_ok) g_addr = free_q.pop_front();
        if (hit) begin
            f_addr = q_model[{rdst.port, rdst.prio}].pop_front();
            f_last = m_last[f_addr];   // flag seen before this edge clears it
        end
        if (grant_ok) q_model[{wdst.port, wdst.prio}].push_back(g_addr);
        if (e && m_granted_any) m_last[m_last_granted] = 1'b1;
        if (hit) begin
            m_last[f_addr] = 1'b0;
            free_q.push_back(f_addr);   // freed cell queues behind the rest
        end
        if (grant_ok) begin
            m_last_granted = g_addr;
            m_granted_any  = 1'b1;
        end
        exp_alloc_valid = grant_ok;
        if (grant_ok) exp_alloc_addr = g_addr;
        exp_rd_valid = hit;
        if (hit) exp_rd_cell = rd_cell_t'{addr: f_addr, last: f_last};
        @(posedge clk);
        #10;
        check_outputs();
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        idle    = '0;
        rst     = 1'b1;
        wr_req  = 1'b0;
        eop     = 1'b0;
        wr_dest = '0;
        rd_req  = 1'b0;
        rd_dest = '0;
        for (int i = 0; i < NUM_CELLS; i++) free_q.push_back(cell_addr_t'(i));
        m_last          = '0;
        m_last_granted  = '0;
        m_granted_any   = 1'b0;
        exp_alloc_valid = 1'b0;
        exp_rd_valid    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst = 1'b0;
        check_outputs();   // idle outputs straight after reset

        // all 16 cells in order, four per queue of ports 0/1 prios 0/1
        for (int i = 0; i < NUM_CELLS; i++) begin
            run_cycle(1'b1, 1'b0, to_dest(i % 2, (i / 2) % 2), 1'b0, idle);
            check_addr("alloc_addr", alloc_addr, cell_addr_t'(i));
        end
        run_cycle(1'b0, 1'b1, idle, 1'b0, idle);   // eop marks cell 15

        // pool exhausted
        check_bit("pool_empty", pool_empty, 1'b1);
        run_cycle(1'b1, 1'b0, to_dest(3, 3), 1'b0, idle);
        check_bit("alloc_valid", alloc_valid, 1'b0);
        // free in the same cycle does not rescue an alloc on an empty pool
        run_cycle(1'b1, 1'b0, to_dest(3, 3), 1'b1, to_dest(0, 0));
        check_bit("alloc_valid", alloc_valid, 1'b0);
        check_cell("rd_cell", rd_cell, rd_cell_t'{addr: 4'd0, last: 1'b0});
        run_cycle(1'b1, 1'b0, to_dest(3, 3), 1'b0, idle);
        check_addr("alloc_addr", alloc_addr, 4'd0);

        // port 1 prio 1 holds 3, 7, 11, 15 and only 15 ends a packet
        for (int i = 0; i < 4; i++) begin
            run_cycle(1'b0, 1'b0, idle, 1'b1, to_dest(1, 1));
            check_cell("rd_cell", rd_cell, rd_cell_t'{addr: cell_addr_t'(4 * i + 3), last: i == 3});
        end
        run_cycle(1'b0, 1'b0, idle, 1'b1, to_dest(1, 1));
        check_bit("rd_valid", rd_valid, 1'b0);
        run_cycle(1'b0, 1'b0, idle, 1'b1, to_dest(2, 2));
        check_bit("rd_valid", rd_valid, 1'b0);

        // the same four cells come back around, flag of 15 now cleared
        for (int i = 0; i < 4; i++) run_cycle(1'b1, 1'b0, to_dest(2, 0), 1'b0, idle);
        for (int i = 0; i < 4; i++) begin
            run_cycle(1'b0, 1'b0, idle, 1'b1, to_dest(2, 0));
            check_cell("rd_cell", rd_cell, rd_cell_t'{addr: cell_addr_t'(4 * i + 3), last: 1'b0});
        end

        // random mix, reads sparse in the first half so the pool runs dry
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            r     = $random(seed);
            wd    = r[11:8];
            rdd   = r[15:12];
            rd_on = (c < RANDOM_CYCLES / 2) ? (r[1] & r[5]) : r[1];
            run_cycle(r[0], r[4:2] == 3'd0, wd, rd_on, rdd);
        end

        $display("errors: flag %0d, addr %0d, cell %0d, mask %0d",
                 flag_errors, addr_errors, cell_errors, mask_errors);
        if (flag_errors + addr_errors + cell_errors + mask_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* cell_manager.f */
hdl/cm_pkg.sv
hdl/cell_pool.sv
hdl/port_queue.sv
hdl/dequeue_select.sv
hdl/cell_manager.sv
testbench/tb_clock.sv
testbench/tb_cell_manager.sv

/* Makefile */
# Verilator build and run of the cell manager testbench

VERILATOR ?= verilator
TOP       ?= tb_cell_manager
FILELIST  ?= cell_manager.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
